/* common/isr_decoder_pkg.sv */
package isr_decoder_pkg;

    // operand addressing modes
    localparam logic [1:0] MODE_D  = 2'b00;
    localparam logic [1:0] MODE_I  = 2'b01;
    localparam logic [1:0] MODE_MI = 2'b10;
    localparam logic [1:0] MODE_IP = 2'b11;

    localparam logic [5:0] OPC_HLT = 6'b000000;
    localparam logic [5:0] OPC_CLR = 6'b000100;
    localparam logic [5:0] OPC_ASL = 6'b001000;
    localparam logic [5:0] OPC_ASR = 6'b001001;
    localparam logic [5:0] OPC_RLC = 6'b001010;
    localparam logic [5:0] OPC_RRC = 6'b001011;
    localparam logic [5:0] OPC_LSL = 6'b001100;
    localparam logic [5:0] OPC_LSR = 6'b001101;
    localparam logic [5:0] OPC_ROL = 6'b001110;
    localparam logic [5:0] OPC_ROR = 6'b001111;
    localparam logic [5:0] OPC_MOV = 6'b010000;
    localparam logic [5:0] OPC_JMP = 6'b010001;
    localparam logic [5:0] OPC_RET = 6'b010010;
    localparam logic [5:0] OPC_RIT = 6'b010011;
    localparam logic [5:0] OPC_ADD = 6'b010100;
    localparam logic [5:0] OPC_RJP = 6'b010101;
    localparam logic [5:0] OPC_ADC = 6'b010110;
    localparam logic [5:0] OPC_SUB = 6'b011000;
    localparam logic [5:0] OPC_SBC = 6'b011010;
    localparam logic [5:0] OPC_CMP = 6'b011011;
    localparam logic [5:0] OPC_OR  = 6'b100000;
    localparam logic [5:0] OPC_XOR = 6'b100001;
    localparam logic [5:0] OPC_AND = 6'b100010;
    localparam logic [5:0] OPC_BIT = 6'b100011;
    localparam logic [5:0] OPC_MUL = 6'b100100;
    localparam logic [5:0] OPC_JSR = 6'b101100;
    localparam logic [5:0] OPC_RJS = 6'b101101;
    localparam logic [5:0] OPC_SVC = 6'b101110;
    localparam logic [5:0] OPC_BRN = 6'b110000;
    localparam logic [5:0] OPC_BRZ = 6'b110001;
    localparam logic [5:0] OPC_BRV = 6'b110010;
    localparam logic [5:0] OPC_BRC = 6'b110011;
    localparam logic [5:0] OPC_RBN = 6'b111000;
    localparam logic [5:0] OPC_RBZ = 6'b111001;
    localparam logic [5:0] OPC_RBV = 6'b111010;
    localparam logic [5:0] OPC_RBC = 6'b111011;

    // nop class is matched on the upper four bits only
    localparam logic [3:0] GRP_NOP = 4'b0111;

    typedef union packed {
        logic [5:0] code;
        struct packed {
            logic [3:0] group;
            logic [1:0] sub;
        } grp;
    } opcode_u;

    typedef struct packed {
        opcode_u    opcode;
        logic [1:0] f_mode;
        logic [2:0] f_reg;
        logic [1:0] t_mode;
        logic [2:0] t_reg;
    } isr_t;

    typedef struct packed {
        logic if0, if1, ff0, ff1, ff2, tf0, tf1, ex1;
    } phase_t;

    typedef struct packed {
        logic n, z, v, c;
    } psw_t;

    typedef struct packed {
        logic hlt, clr;
        logic asl, asr, rlc, rrc, lsl, lsr, rol, ror;
        logic mov, jmp, ret, rit, add, rjp, adc, sub, sbc, cmp;
        logic or_inst, xor_inst, and_inst, bit_inst, mul;
        logic jsr, rjs, svc;
        logic brn, brz, brv, brc, rbn, rbz, rbv, rbc;
        logic nop;
    } op_flags_t;

    typedef struct packed {
        logic [7:0] reg_rd;
        logic       mda, b0b, smd, sma;
    } src_ctrl_t;

    typedef struct packed {
        logic [7:0] reg_wr;
        logic       sb0;
    } dst_ctrl_t;

    typedef struct packed {
        logic als, alu_x, alu_y, alu_z, alu_u, alu_v, shs;
        logic sft_a, sft_b, sft_c, sft_d, sft_e, sft_r, sft_l;
        logic set_psw;
    } alu_ctrl_t;

endpackage

/* hdl/opcode_decode.sv */
module opcode_decode (
    input  isr_decoder_pkg::opcode_u   opcode,
    output isr_decoder_pkg::op_flags_t op
);
    import isr_decoder_pkg::*;

    assign op.hlt      = (opcode.code == OPC_HLT);
    assign op.clr      = (opcode.code == OPC_CLR);

    // shifts and rotates
    assign op.asl      = (opcode.code == OPC_ASL);
    assign op.asr      = (opcode.code == OPC_ASR);
    assign op.rlc      = (opcode.code == OPC_RLC);
    assign op.rrc      = (opcode.code == OPC_RRC);
    assign op.lsl      = (opcode.code == OPC_LSL);
    assign op.lsr      = (opcode.code == OPC_LSR);
    assign op.rol      = (opcode.code == OPC_ROL);
    assign op.ror      = (opcode.code == OPC_ROR);

    assign op.mov      = (opcode.code == OPC_MOV);
    assign op.jmp      = (opcode.code == OPC_JMP);
    assign op.ret      = (opcode.code == OPC_RET);
    assign op.rit      = (opcode.code == OPC_RIT);
    assign op.add      = (opcode.code == OPC_ADD);
    assign op.rjp      = (opcode.code == OPC_RJP);
    assign op.adc      = (opcode.code == OPC_ADC);
    assign op.sub      = (opcode.code == OPC_SUB);
    assign op.sbc      = (opcode.code == OPC_SBC);
    assign op.cmp      = (opcode.code == OPC_CMP);

    // logic ops and multiply
    assign op.or_inst  = (opcode.code == OPC_OR);
    assign op.xor_inst = (opcode.code == OPC_XOR);
    assign op.and_inst = (opcode.code == OPC_AND);
    assign op.bit_inst = (opcode.code == OPC_BIT);
    assign op.mul      = (opcode.code == OPC_MUL);

    assign op.jsr      = (opcode.code == OPC_JSR);
    assign op.rjs      = (opcode.code == OPC_RJS);
    assign op.svc      = (opcode.code == OPC_SVC);

    // conditional branches, absolute then relative
    assign op.brn      = (opcode.code == OPC_BRN);
    assign op.brz      = (opcode.code == OPC_BRZ);
    assign op.brv      = (opcode.code == OPC_BRV);
    assign op.brc      = (opcode.code == OPC_BRC);
    assign op.rbn      = (opcode.code == OPC_RBN);
    assign op.rbz      = (opcode.code == OPC_RBZ);
    assign op.rbv      = (opcode.code == OPC_RBV);
    assign op.rbc      = (opcode.code == OPC_RBC);

    // sub field is a don't care for the nop group
    assign op.nop      = (opcode.grp.group == GRP_NOP);

endmodule

/* reg_select/src_select.sv */
module src_select (
    input  isr_decoder_pkg::phase_t    phase,
    input  isr_decoder_pkg::op_flags_t op,
    input  logic [1:0]                 f_mode,
    input  logic [2:0]                 f_reg,
    input  logic [1:0]                 t_mode,
    input  logic [2:0]                 t_reg,
    output isr_decoder_pkg::src_ctrl_t src
);
    import isr_decoder_pkg::*;

    logic       f_ip;
    logic       t_ip;
    logic [7:0] f_hit;
    logic [7:0] t_hit;
    logic [7:0] fixed_rd;
    logic       shift_op;
    logic       logic_op;
    logic       br_op;
    logic       rb_op;

    assign f_ip  = (f_mode == MODE_IP);
    assign t_ip  = (t_mode == MODE_IP);
    assign f_hit = 8'd1 << f_reg;
    assign t_hit = 8'd1 << t_reg;

    assign shift_op = op.asl | op.asr | op.rlc | op.rrc | op.lsl | op.lsr | op.rol | op.ror;
    assign logic_op = op.or_inst | op.xor_inst | op.and_inst | op.bit_inst;
    assign br_op    = op.brn | op.brz | op.brv | op.brc;
    assign rb_op    = op.rbn | op.rbz | op.rbv | op.rbc;

    // r7 is the pc, r6 the stack pointer
    assign fixed_rd = {phase.if0 | phase.if1 | (op.rjs & phase.ex1), op.ret | op.rit, 6'b0};

    assign src.reg_rd = ({8{phase.ff0}} & f_hit) |
                        ({8{phase.ff1 & f_ip}} & f_hit) |
                        ({8{phase.tf0}} & t_hit) |
                        ({8{phase.tf1 & t_ip}} & t_hit) |
                        fixed_rd;

    assign src.mda = phase.ff2 | shift_op | op.add | op.adc | op.rjp |
                     op.sub | op.sbc | op.cmp | logic_op | rb_op;

    assign src.b0b = op.mov | op.jmp | op.ret | op.rit | op.add | op.rjp | op.adc |
                     op.sub | op.sbc | op.cmp | logic_op |
                     op.jsr | op.rjs | op.svc | br_op | rb_op | phase.ex1;

    assign src.smd = phase.if0 | phase.ff0 | phase.tf0 | op.clr | shift_op | op.mov |
                     op.add | op.adc | op.rjp | op.sub | op.sbc |
                     op.or_inst | op.xor_inst | op.and_inst | op.jsr | op.rjs | op.svc;

    assign src.sma = phase.if0 | phase.ff0 | phase.tf0;

endmodule

/* reg_select/dst_select.sv */
module dst_select (
    input  isr_decoder_pkg::phase_t    phase,
    input  isr_decoder_pkg::op_flags_t op,
    input  isr_decoder_pkg::psw_t      psw,
    input  logic [1:0]                 f_mode,
    input  logic [2:0]                 f_reg,
    input  logic [1:0]                 t_mode,
    input  logic [2:0]                 t_reg,
    output isr_decoder_pkg::dst_ctrl_t dst
);
    import isr_decoder_pkg::*;

    logic       f_ip;
    logic       t_ip;
    logic       t_d;
    logic [7:0] f_hit;
    logic [7:0] t_hit;
    logic       reg_op;
    logic       br_take;
    logic       pc_wr;

    assign f_ip  = (f_mode == MODE_IP);
    assign t_ip  = (t_mode == MODE_IP);
    assign t_d   = (t_mode == MODE_D);
    assign f_hit = 8'd1 << f_reg;
    assign t_hit = 8'd1 << t_reg;

    // opcodes that write their result back to a register destination
    assign reg_op = op.clr |
                    op.asl | op.asr | op.rlc | op.rrc | op.lsl | op.lsr | op.rol | op.ror |
                    op.mov | op.add | op.adc | op.rjp |
                    op.or_inst | op.xor_inst | op.and_inst;

    // taken branch when the selected flag is set
    assign br_take = ((op.brn | op.rbn) & psw.n) |
                     ((op.brz | op.rbz) & psw.z) |
                     ((op.brv | op.rbv) & psw.v) |
                     ((op.brc | op.rbc) & psw.c);

    assign pc_wr = op.jmp | op.ret | op.rit | br_take |
                   (phase.ex1 & (op.jsr | op.rjs | op.svc));

    assign dst.reg_wr = ({8{phase.ff0}} & f_hit) |
                        ({8{phase.ff1 & f_ip}} & f_hit) |
                        ({8{phase.tf1 & t_ip}} & t_hit) |
                        ({8{reg_op & t_d}} & t_hit) |
                        {pc_wr, 7'b0};

    assign dst.sb0 = phase.ff2;

endmodule

/* hdl/alu_control.sv */
module alu_control (
    input  isr_decoder_pkg::phase_t    phase,
    input  isr_decoder_pkg::op_flags_t op,
    input  isr_decoder_pkg::psw_t      psw,
    input  logic [1:0]                 f_mode,
    output isr_decoder_pkg::alu_ctrl_t alu
);
    import isr_decoder_pkg::*;

    logic shift_op;
    logic logic_op;
    logic br_op;
    logic rb_op;
    logic arith_op;
    logic sub_op;

    assign shift_op = op.asl | op.asr | op.rlc | op.rrc | op.lsl | op.lsr | op.rol | op.ror;
    assign logic_op = op.or_inst | op.xor_inst | op.and_inst | op.bit_inst;
    assign br_op    = op.brn | op.brz | op.brv | op.brc;
    assign rb_op    = op.rbn | op.rbz | op.rbv | op.rbc;

    // mov up to cmp in opcode order
    assign arith_op = op.mov | op.jmp | op.ret | op.rit | op.add | op.rjp | op.adc |
                      op.sub | op.sbc | op.cmp;
    assign sub_op   = op.sub | op.sbc | op.cmp;

    assign alu.als = (|phase) | op.clr | arith_op | logic_op |
                     op.jsr | op.rjs | op.svc | br_op | rb_op;

    // minus-indexed source needs the decrement path
    assign alu.alu_x = (phase.ff0 & (f_mode == MODE_MI)) | sub_op;

    assign alu.alu_y = phase.if0 | phase.if1 | phase.ff0 | phase.ff2 |
                       phase.tf0 | phase.tf1 | phase.ex1 |
                       arith_op | op.jsr | op.rjs | op.svc | br_op;

    assign alu.alu_z = op.or_inst | rb_op;

    // carry in, forced for subtract and taken from psw for the with-carry forms
    assign alu.alu_u = phase.if1 | phase.tf1 | op.sub | op.cmp |
                       ((op.adc | op.sbc) & psw.c);

    assign alu.alu_v = alu.alu_y | op.xor_inst | rb_op;

    assign alu.shs   = shift_op;
    assign alu.sft_a = op.asr;
    assign alu.sft_b = op.rol;
    assign alu.sft_c = op.lsr | op.rol | op.rlc;
    assign alu.sft_d = op.ror;
    assign alu.sft_e = op.rlc | op.rrc;
    assign alu.sft_r = op.asr | op.ror | op.rrc;
    assign alu.sft_l = op.asr | op.lsr | op.rol | op.rlc;

    assign alu.set_psw = op.clr | shift_op | op.mov | op.add | op.adc |
                         sub_op | logic_op;

endmodule

/* hdl/isr_decoder.sv */
module isr_decoder (
    input  isr_decoder_pkg::isr_t      isr,
    input  isr_decoder_pkg::phase_t    phase,
    input  isr_decoder_pkg::psw_t      psw,
    output isr_decoder_pkg::src_ctrl_t src,
    output isr_decoder_pkg::dst_ctrl_t dst,
    output isr_decoder_pkg::alu_ctrl_t alu
);
    import isr_decoder_pkg::*;

    op_flags_t  op;
    opcode_u    opcode;
    logic [1:0] f_mode;
    logic [2:0] f_reg;
    logic [1:0] t_mode;
    logic [2:0] t_reg;

    // isr fields
    assign opcode = isr.opcode;
    assign f_mode = isr.f_mode;
    assign f_reg  = isr.f_reg;
    assign t_mode = isr.t_mode;
    assign t_reg  = isr.t_reg;

    opcode_decode u_opcode_decode (.opcode(opcode), .op(op));

    src_select u_src_select (
        .phase(phase), .op(op), .f_mode(f_mode), .f_reg(f_reg),
        .t_mode(t_mode), .t_reg(t_reg), .src(src)
    );

    dst_select u_dst_select (
        .phase(phase), .op(op), .psw(psw), .f_mode(f_mode), .f_reg(f_reg),
        .t_mode(t_mode), .t_reg(t_reg), .dst(dst)
    );

    alu_control u_alu_control (
        .phase(phase), .op(op), .psw(psw), .f_mode(f_mode), .alu(alu)
    );

endmodule

/* dv/isr_decoder_tb.sv */
module isr_decoder_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import isr_decoder_pkg::*;

    localparam int WORDS   = 7;
    localparam int MAX_VEC = 128;

    logic clk = 1'b0;
    logic rst = 1'b1;

    isr_t      isr;
    phase_t    phase;
    psw_t      psw;
    src_ctrl_t src;
    dst_ctrl_t dst;
    alu_ctrl_t alu;

    // each vector is seven words of tag isr phase psw src dst alu
    logic [15:0] pat_mem [0:MAX_VEC*WORDS-1];
    int          num_vec = 0;

    isr_decoder UUT (
        .isr(isr),
        .phase(phase),
        .psw(psw),
        .src(src),
        .dst(dst),
        .alu(alu)
    );

    always #10 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_word(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // vectors end at the first unloaded tag word
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VEC && !$isunknown(pat_mem[n * WORDS])) begin
            n++;
        end
        return n;
    endfunction

    task automatic apply_vector(input int idx);
        int base;
        base  = idx * WORDS;
        isr   = pat_mem[base + 1];
        phase = pat_mem[base + 2][7:0];
        psw   = pat_mem[base + 3][3:0];
    endtask

    task automatic check_vector(input int idx);
        int    base;
        string tag;
        base = idx * WORDS;
        tag  = $sformatf("case%0h_vec%0d", pat_mem[base], idx);
        compare_word({tag, "_src"}, pat_mem[base + 4], {4'b0, src});
        compare_word({tag, "_dst"}, pat_mem[base + 5], {7'b0, dst});
        compare_word({tag, "_alu"}, pat_mem[base + 6], {1'b0, alu});
    endtask

    initial begin
        isr   = '0;
        phase = '0;
        psw   = '0;
        $readmemh("dv/isr_decoder_patterns.hex", pat_mem);

        num_vec = count_vectors();
        if (num_vec == 0) begin
            stop_run("no vectors were read from the pattern file");
        end

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // drive just after the edge and sample on the next one
        for (int i = 0; i < num_vec; i++) begin
            apply_vector(i);
            @(posedge clk);
            check_vector(i);
            #2;
        end

        $display("Test passed");
        $finish;
    end

    // one clock per vector plus reset and some slack
    initial begin
        wait (num_vec > 0);
        #((num_vec + 20) * 20);
        stop_run("watchdog timeout, the pattern run did not finish in time");
    end

endmodule

/* dv/isr_decoder_patterns.hex */
// columns: tag isr phase psw, then expected src dst alu, all hex
// tag is the test group 1..6, src/dst/alu are zero-extended to 16 bits
1 0005 00 0 000 000 0000
1 1005 00 0 002 040 4001
1 2005 00 0 00A 040 0101
1 2405 00 0 00A 040 0187
1 2805 00 0 00A 040 012B
1 2C05 00 0 00A 040 010D
1 3005 00 0 00A 040 0101
1 3405 00 0 00A 040 0123
1 3805 00 0 00A 040 0163
1 3C05 00 0 00A 040 0115
1 4005 00 0 006 040 5201
1 4405 00 0 004 100 5200
1 4805 00 0 404 100 5200
1 4C05 00 0 404 100 5200
1 5005 00 0 00E 040 5201
1 5405 00 0 00E 040 5200
1 5805 00 0 00E 040 5201
1 6005 00 0 00E 000 7601
1 6805 00 0 00E 000 7201
1 6C05 00 0 00C 000 7601
1 8005 00 0 00E 040 4801
1 8405 00 0 00E 040 4201
1 8805 00 0 00E 040 4001
1 8C05 00 0 00C 000 4001
1 9005 00 0 000 000 0000
1 B005 00 0 006 000 5200
1 B405 00 0 006 000 5200
1 B805 00 0 006 000 5200
1 C005 00 0 004 000 5200
1 C405 00 1 004 000 5200
1 C805 00 2 004 100 5200
1 CC05 00 3 004 100 5200
1 E005 00 4 00C 000 4A00
1 E405 00 5 00C 100 4A00
1 E805 00 6 00C 100 4A00
1 EC05 00 7 00C 100 4A00
2 7000 80 0 803 000 5200
2 7000 40 0 800 000 5600
2 727E 20 0 083 010 7200
2 70C0 20 0 403 080 5200
2 73A0 10 0 200 040 4000
2 71A0 10 0 000 000 4000
2 7000 08 0 008 001 5200
2 70F2 04 0 043 000 5200
2 7019 02 0 020 004 5600
2 7009 02 0 000 000 5600
3 400D 00 0 006 000 5201
3 5018 00 0 00E 000 5201
3 1017 00 0 002 000 4001
3 3C07 00 0 00A 100 0115
3 8400 00 0 00E 002 4201
4 CC05 00 8 004 000 5200
4 C805 00 9 004 000 5200
4 C405 00 A 004 000 5200
4 C005 00 B 004 100 5200
4 EC05 00 C 00C 000 4A00
4 E805 00 D 00C 000 4A00
4 E405 00 E 00C 100 4A00
4 E005 00 F 00C 100 4A00
4 5805 00 1 00E 040 5601
4 6805 00 1 00E 000 7601
5 73FF 00 F 000 000 0000
5 7405 00 0 000 000 0000
5 7805 00 5 000 000 0000
5 7C05 00 A 000 000 0000
5 0405 00 F 000 000 0000
6 B005 01 0 006 100 5200
6 B405 01 0 806 100 5200
6 B805 01 0 006 100 5200

/* isr_decoder.f */
common/isr_decoder_pkg.sv
hdl/opcode_decode.sv
reg_select/src_select.sv
reg_select/dst_select.sv
hdl/alu_control.sv
hdl/isr_decoder.sv
dv/isr_decoder_tb.sv

/* Bender.yml */
package:
  name: isr_decoder

sources:
  - common/isr_decoder_pkg.sv
  - hdl/opcode_decode.sv
  - reg_select/src_select.sv
  - reg_select/dst_select.sv
  - hdl/alu_control.sv
  - hdl/isr_decoder.sv
  - target: test
    files:
      - dv/isr_decoder_tb.sv
